//--- sources.f
autoPkg.sv
sportAutoBuf.sv
stealCtl.sv
autoAddrGen.sv
dspMem.sv
autoSubsys.sv
tbClock.sv
tbAutoSubsys.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tbAutoSubsys -o simv \
  && ./obj_dir/simv 2>&1 | tee sim.log
grep -q "^TESTBENCH PASSED$" sim.log && exit 0 || exit 1

//--- tbAutoSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module tbAutoSubsys;
  import autoPkg::*;

  localparam int NumWords      = 64;                // DMA traffic stays inside the preloaded area
  localparam int RandCycles    = 1400;
  localparam int GateCycles    = 10;
  localparam int TimeoutCycles = 4 * 2 * NumWords + RandCycles + 3 * GateCycles + 200;

  logic                 DSPCLK;
  logic                 RST;
  logic [NumSport-1:0]  rxStrobe;
  logic [WordW-1:0]     rxWord [NumSport];
  logic [NumSport-1:0]  txTake;
  logic [NumSport-1:0]  autoEn;
  logic                 goEx;
  logic                 stby;
  logic                 boot;
  logic                 iceStop;
  logic                 dmaReq;
  logic                 bdmaReq;
  dmaCmdT               dmaCmd;
  dmaCmdT               bdmaCmd;
  circCfgT              cfg [NumAutoCh];
  logic [WordW-1:0]     txWord [NumSport];
  logic [NumSport-1:0]  rxOverrun;
  logic                 sreq;
  logic                 steal;
  logic                 dmaAck;
  logic                 bdmaAck;
  logic [WordW-1:0]     dmaRdData;

  // Model ack bits are ordered t0 r0 t1 r1 dma bdma from the top
  logic [5:0]           mAck;
  logic                 mSteal;
  logic [NumSport-1:0]  mrReq;
  logic [NumSport-1:0]  mtReq;
  logic [NumSport-1:0]  mOvr;
  logic [NumSport-1:0]  mTxValid;
  logic [WordW-1:0]     mRxHold [NumSport];
  logic [WordW-1:0]     mTxWord [NumSport];
  logic [AddrW-1:0]     mIdx [NumAutoCh];
  logic [WordW-1:0]     mRd;
  logic                 mRdValid;
  logic [WordW-1:0]     shDm [MemDepth];
  logic [WordW-1:0]     shPm [MemDepth];
  logic [15:0]          lfsrState = 16'd75;
  int                   cycleCount = 0;
  int                   dmaServed;

  tbClock uClk (.DSPCLK);

  autoSubsys UUT (.*);

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return v;
  endfunction

  function automatic dmaCmdT randCmd();
    dmaCmdT c;
    logic [1:0] sel;
    sel = takeBits(2);
    c.op = (sel == 0) ? OpDmRd : (sel == 1) ? OpDmWr : (sel == 2) ? OpPmRd : OpPmWr;
    c.addr = takeBits(6);
    c.wrData = takeBits(16);
    return c;
  endfunction

  task automatic stopFail(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stopFail($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // Compare the DUT with the model, then advance the model across the coming edge
  task automatic modelCycle();
    logic [5:0]       req;
    logic [5:0]       live;
    logic             goSpt;
    logic             sreqM;
    logic             en;
    int               s;
    memOpT            op;
    logic [AddrW-1:0] a;
    logic [WordW-1:0] wd;
    req   = {mtReq[0], mrReq[0], mtReq[1], mrReq[1], dmaReq, bdmaReq};
    live  = req & ~mAck & (iceStop ? 6'b000010 : 6'b111111);
    goSpt = goEx | stby | mSteal;
    sreqM = (|live) & (goSpt | boot);
    checkEq("steal", steal, mSteal);
    checkEq("sreq", sreq, sreqM);
    checkEq("ack", UUT.ack, mAck);
    checkEq("dmaAck", dmaAck, mAck[1]);
    checkEq("bdmaAck", bdmaAck, mAck[0]);
    if (!(mAck[1] | mAck[0]))
      checkEq("dmaRdData", dmaRdData, 0);
    else if (mRdValid)
      checkEq("dmaRdData", dmaRdData, mRd);
    checkEq("rxOverrun", rxOverrun, mOvr);
    for (int p = 0; p < NumSport; p++)
      if (mTxValid[p])
        checkEq($sformatf("txWord[%0d]", p), txWord[p], mTxWord[p]);

    s = 6;
    for (int i = 0; i < 6; i++)
      if (s == 6 && live[5-i])
        s = i;
    en = 1'b0;
    op = OpNone;
    a  = '0;
    wd = '0;
    case (s)
      0, 2:
      begin
        en = goSpt;
        op = OpDmRd;
      end
      1, 3:
      begin
        en = goSpt;
        op = OpDmWr;
        wd = mRxHold[s/2];
      end
      4:
      begin
        en = goSpt | boot | iceStop;
        op = dmaCmd.op;
        a  = dmaCmd.addr;
        wd = dmaCmd.wrData;
      end
      5:
      begin
        en = goSpt | boot;
        op = bdmaCmd.op;
        a  = bdmaCmd.addr;
        wd = bdmaCmd.wrData;
      end
      default: ;
    endcase
    if (s < 4)
      a = cfg[s].base + mIdx[s];
    if (!en)
      op = OpNone;

    for (int p = 0; p < NumSport; p++)
    begin
      if (rxStrobe[p] && autoEn[p])
      begin
        if (mrReq[p] && !mAck[4-2*p])
          mOvr[p] = 1'b1;
        mrReq[p]   = 1'b1;
        mRxHold[p] = rxWord[p];
      end
      else if (mAck[4-2*p])
        mrReq[p] = 1'b0;
      if (txTake[p] && autoEn[p])
        mtReq[p] = 1'b1;
      else if (mAck[5-2*p])
        mtReq[p] = 1'b0;
      if (mAck[5-2*p])
      begin
        mTxWord[p]  = mRd;                          // Word read in the cycle before the ack
        mTxValid[p] = mRdValid;
      end
    end

    case (op)
      OpDmWr: shDm[a] = wd;
      OpPmWr: shPm[a] = wd;
      OpDmRd:
      begin
        mRd      = shDm[a];
        mRdValid = 1'b1;
      end
      OpPmRd:
      begin
        mRd      = shPm[a];
        mRdValid = 1'b1;
      end
      default: ;
    endcase
    if (s < 4 && op != OpNone)
      mIdx[s] = (int'(mIdx[s]) + 1 >= int'(cfg[s].len)) ? '0 : mIdx[s] + 1'b1;
    mSteal = sreqM;
    mAck   = en ? (6'b100000 >> s) : 6'b0;
  endtask

  task automatic stepCycle();
    @(negedge DSPCLK);
    modelCycle();
    @(posedge DSPCLK);
    #1;
  endtask

  task automatic dmaXfer(input logic byteDma, input memOpT op, input logic [AddrW-1:0] a,
                         input logic [WordW-1:0] d);
    dmaCmdT cmd;
    cmd = '{op: op, addr: a, wrData: d};
    if (byteDma)
    begin
      bdmaReq = 1'b1;
      bdmaCmd = cmd;
    end
    else
    begin
      dmaReq = 1'b1;
      dmaCmd = cmd;
    end
    do
      stepCycle();
    while (!(byteDma ? mAck[0] : mAck[1]));
    if (byteDma)
      bdmaReq = 1'b0;
    else
      dmaReq = 1'b0;
  endtask

  task automatic driveRandom();
    for (int p = 0; p < NumSport; p++)
    begin
      rxStrobe[p] = (takeBits(2) == 0);
      rxWord[p]   = takeBits(16);
      txTake[p]   = (takeBits(2) == 0);
    end
    goEx    = (takeBits(2) != 0);
    stby    = (takeBits(3) == 0);
    boot    = (takeBits(4) == 0);
    iceStop = (takeBits(4) == 0);
    if (!dmaReq || mAck[1])                         // A DMA request holds until it is acknowledged
    begin
      dmaReq = takeBits(1);
      dmaCmd = randCmd();
    end
    if (!bdmaReq || mAck[0])
    begin
      bdmaReq = takeBits(1);
      bdmaCmd = randCmd();
    end
  endtask

  always @(posedge DSPCLK)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
      stopFail($sformatf("Timeout: run did not finish within %0d cycles", TimeoutCycles));
  end

  initial
  begin
    RST = 1'b1;
    rxStrobe = '0;
    txTake = '0;
    autoEn = '0;
    goEx = 1'b1;
    stby = 1'b0;
    boot = 1'b0;
    iceStop = 1'b0;
    dmaReq = 1'b0;
    bdmaReq = 1'b0;
    dmaCmd = '0;
    bdmaCmd = '0;
    rxWord = '{default: '0};
    cfg[0] = '{base: 8'h08, len: 8'd8};
    cfg[1] = '{base: 8'h18, len: 8'd5};
    cfg[2] = '{base: 8'h28, len: 8'd6};
    cfg[3] = '{base: 8'h30, len: 8'd7};
    mAck = '0;
    mSteal = 1'b0;
    mrReq = '0;
    mtReq = '0;
    mOvr = '0;
    mTxValid = '0;
    mRxHold = '{default: '0};
    mTxWord = '{default: '0};
    mIdx = '{default: '0};
    mRd = '0;
    mRdValid = 1'b0;
    repeat (3) @(posedge DSPCLK);
    #1 RST = 1'b0;

    for (int a = 0; a < NumWords; a++)
    begin
      dmaXfer(1'b0, OpDmWr, a[AddrW-1:0], takeBits(16));
      dmaXfer(1'b1, OpPmWr, a[AddrW-1:0], takeBits(16));
    end

    autoEn = 2'b11;
    repeat (RandCycles)
    begin
      driveRandom();
      stepCycle();
    end

    // Pending serial work drains with the core running, then the halted core serves nothing
    {stby, boot, iceStop, dmaReq, bdmaReq} = '0;
    goEx = 1'b1;
    rxStrobe = '0;
    txTake = '0;
    do
      stepCycle();
    while (mrReq != 0 || mtReq != 0);
    goEx = 1'b0;
    while (mSteal)
      stepCycle();
    rxStrobe = 2'b11;
    txTake = 2'b11;
    {dmaReq, bdmaReq} = 2'b11;
    dmaCmd = '{op: OpDmRd, addr: 8'h02, wrData: '0};
    bdmaCmd = '{op: OpPmRd, addr: 8'h03, wrData: '0};
    stepCycle();
    rxStrobe = '0;
    txTake = '0;
    repeat (GateCycles)
    begin
      stepCycle();
      checkEq("ack", UUT.ack, 0);
    end

    iceStop = 1'b1;
    goEx = 1'b1;
    dmaServed = 0;
    repeat (GateCycles)
    begin
      stepCycle();
      checkEq("ack", UUT.ack & 6'b111101, 0);
      dmaServed += dmaAck;
    end
    if (dmaServed == 0)
      stopFail("Host DMA was never served while iceStop was high");

    {iceStop, goEx, boot} = 3'b001;
    repeat (GateCycles)
      stepCycle();

    {boot, goEx, autoEn, dmaReq, bdmaReq} = 6'b010000;
    for (int a = 0; a < NumWords; a++)
    begin
      dmaXfer(1'b0, OpDmRd, a[AddrW-1:0], '0);
      dmaXfer(1'b1, OpPmRd, a[AddrW-1:0], '0);
    end
    stepCycle();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic DSPCLK
);

  initial
  begin
    DSPCLK = 1'b0;
    forever
      #50 DSPCLK = ~DSPCLK;                         // 100 ns period
  end

endmodule

`default_nettype wire

//--- autoSubsys.sv
`timescale 1ns/1ps
`default_nettype none

module autoSubsys (
  input  logic                           DSPCLK,
  input  logic                           RST,
  input  logic [autoPkg::NumSport-1:0]   rxStrobe,
  input  logic [autoPkg::WordW-1:0]      rxWord [autoPkg::NumSport],
  input  logic [autoPkg::NumSport-1:0]   txTake,
  input  logic [autoPkg::NumSport-1:0]   autoEn,
  input  logic                           goEx,
  input  logic                           stby,
  input  logic                           boot,
  input  logic                           iceStop,
  input  logic                           dmaReq,
  input  logic                           bdmaReq,
  input  autoPkg::dmaCmdT                dmaCmd,
  input  autoPkg::dmaCmdT                bdmaCmd,
  input  autoPkg::circCfgT               cfg [autoPkg::NumAutoCh],
  output logic [autoPkg::WordW-1:0]      txWord [autoPkg::NumSport],
  output logic [autoPkg::NumSport-1:0]   rxOverrun,
  output logic                           sreq,
  output logic                           steal,
  output logic                           dmaAck,
  output logic                           bdmaAck,
  output logic [autoPkg::WordW-1:0]      dmaRdData
);
  import autoPkg::*;

  stealReqT         spReq;
  stealReqT         allReq;
  stealReqT         ack;
  stealSrcT         winner;
  memOpT            memOp;
  logic [WordW-1:0] wrData;
  logic [WordW-1:0] rdData;
  logic [AddrW-1:0] addr;
  logic [WordW-1:0] rxHold [NumSport];

  assign allReq = '{
    t0:   spReq.t0,
    r0:   spReq.r0,
    t1:   spReq.t1,
    r1:   spReq.r1,
    dma:  dmaReq,
    bdma: bdmaReq
  };

  assign dmaAck    = ack.dma;
  assign bdmaAck   = ack.bdma;
  assign dmaRdData = (ack.dma | ack.bdma) ? rdData : '0;   // Returned with the DMA acknowledge

  sportAutoBuf uSport (
    .DSPCLK, .RST, .rxStrobe, .rxWord, .txTake, .autoEn,
    .ack, .rdData, .req(spReq), .rxHold, .txWord, .rxOverrun
  );

  stealCtl uSteal (
    .DSPCLK, .RST, .req(allReq), .goEx, .stby, .boot, .iceStop,
    .dmaCmd, .bdmaCmd, .rxHold, .sreq, .steal, .ack, .winner, .memOp, .wrData
  );

  autoAddrGen uAddr (
    .DSPCLK, .RST, .cfg, .winner, .memOp, .dmaCmd, .bdmaCmd, .addr
  );

  dspMem uMem (
    .DSPCLK, .memOp, .addr, .wrData, .rdData
  );

endmodule

`default_nettype wire

//--- dspMem.sv
`timescale 1ns/1ps
`default_nettype none

module dspMem (
  input  logic                      DSPCLK,
  input  autoPkg::memOpT            memOp,
  input  logic [autoPkg::AddrW-1:0] addr,
  input  logic [autoPkg::WordW-1:0] wrData,
  output logic [autoPkg::WordW-1:0] rdData
);
  import autoPkg::*;

  logic [WordW-1:0] dm [MemDepth];                  // Data memory
  logic [WordW-1:0] pm [MemDepth];                  // Program memory, low 16 bits only

  logic dmWe;
  logic pmWe;
  logic rdEn;
  logic rdPm;

  assign dmWe = (memOp == OpDmWr);
  assign pmWe = (memOp == OpPmWr);
  assign rdEn = (memOp == OpDmRd) || (memOp == OpPmRd);
  assign rdPm = (memOp == OpPmRd);

  always_ff @(posedge DSPCLK)
  begin
    if (dmWe)
      dm[addr] <= wrData;
  end

  always_ff @(posedge DSPCLK)
  begin
    if (pmWe)
      pm[addr] <= wrData;
  end

  // Output register holds the last word read until the next read cycle
  always_ff @(posedge DSPCLK)
  begin
    if (rdEn)
    begin
      if (rdPm)
        rdData <= pm[addr];
      else
        rdData <= dm[addr];
    end
  end

endmodule

`default_nettype wire

//--- autoAddrGen.sv
`timescale 1ns/1ps
`default_nettype none

module autoAddrGen (
  input  logic                      DSPCLK,
  input  logic                      RST,
  input  autoPkg::circCfgT          cfg [autoPkg::NumAutoCh],
  input  autoPkg::stealSrcT         winner,
  input  autoPkg::memOpT            memOp,
  input  autoPkg::dmaCmdT           dmaCmd,
  input  autoPkg::dmaCmdT           bdmaCmd,
  output logic [autoPkg::AddrW-1:0] addr
);
  import autoPkg::*;

  logic [AddrW-1:0] idx [NumAutoCh];
  logic [1:0]       ch;
  logic             isAuto;
  logic [AddrW:0]   incIdx;
  logic [AddrW-1:0] nextIdx;

  assign isAuto = winner inside {SrcT0, SrcR0, SrcT1, SrcR1};
  assign ch     = winner[1:0];                      // Autobuffer sources encode their channel

  // One extra bit so an index of 255 still compares against the length
  assign incIdx  = {1'b0, idx[ch]} + 1'b1;
  assign nextIdx = (incIdx >= {1'b0, cfg[ch].len}) ? '0 : incIdx[AddrW-1:0];

  always_comb
  begin
    case (winner)
      SrcDma:  addr = dmaCmd.addr;
      SrcBdma: addr = bdmaCmd.addr;
      default: addr = isAuto ? cfg[ch].base + idx[ch] : '0;
    endcase
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < NumAutoCh; i++)
        idx[i] <= '0;
    end
    else if (isAuto && memOp != OpNone)
    begin
      idx[ch] <= nextIdx;                           // Advance together with the stolen cycle
    end
  end

  for (genvar g = 0; g < NumAutoCh; g++)
  begin : gIdxChk
    idxInRange: assert property (
      @(posedge DSPCLK) disable iff (RST)
      (cfg[g].len != '0) |-> (idx[g] < cfg[g].len)
    ) else $error("autoAddrGen: channel %0d index beyond its length", g);
  end

endmodule

`default_nettype wire

//--- stealCtl.sv
`timescale 1ns/1ps
`default_nettype none

module stealCtl (
  input  logic                         DSPCLK,
  input  logic                         RST,
  input  autoPkg::stealReqT            req,
  input  logic                         goEx,
  input  logic                         stby,
  input  logic                         boot,
  input  logic                         iceStop,
  input  autoPkg::dmaCmdT              dmaCmd,
  input  autoPkg::dmaCmdT              bdmaCmd,
  input  logic [autoPkg::WordW-1:0]    rxHold [autoPkg::NumSport],
  output logic                         sreq,
  output logic                         steal,
  output autoPkg::stealReqT            ack,
  output autoPkg::stealSrcT            winner,
  output autoPkg::memOpT               memOp,
  output logic [autoPkg::WordW-1:0]    wrData
);
  import autoPkg::*;

  stealReqT                   live;
  stealReqT                   ackNext;
  logic                       goSpt;
  logic                       winEn;
  memOpT                      winOp;
  logic [$bits(stealReqT)-1:0] ackBits;

  // A source with its acknowledge high sits out this cycle
  always_comb
  begin
    live.t0   = req.t0 & ~iceStop & ~ack.t0;
    live.r0   = req.r0 & ~iceStop & ~ack.r0;
    live.t1   = req.t1 & ~iceStop & ~ack.t1;
    live.r1   = req.r1 & ~iceStop & ~ack.r1;
    live.dma  = req.dma & ~ack.dma;
    live.bdma = req.bdma & ~iceStop & ~ack.bdma;
  end

  assign goSpt = goEx | steal | stby;
  assign sreq  = (|live) & (goSpt | boot);

  always_comb
  begin
    if (live.t0)
      winner = SrcT0;
    else if (live.r0)
      winner = SrcR0;
    else if (live.t1)
      winner = SrcT1;
    else if (live.r1)
      winner = SrcR1;
    else if (live.dma)
      winner = SrcDma;
    else if (live.bdma)
      winner = SrcBdma;
    else
      winner = SrcNone;
  end

  always_comb
  begin
    winEn   = 1'b0;
    winOp   = OpNone;
    wrData  = '0;
    ackNext = '0;
    case (winner)
      SrcT0:   begin winEn = goSpt; winOp = OpDmRd; ackNext.t0 = 1'b1; end
      SrcR0:   begin winEn = goSpt; winOp = OpDmWr; ackNext.r0 = 1'b1; wrData = rxHold[0]; end
      SrcT1:   begin winEn = goSpt; winOp = OpDmRd; ackNext.t1 = 1'b1; end
      SrcR1:   begin winEn = goSpt; winOp = OpDmWr; ackNext.r1 = 1'b1; wrData = rxHold[1]; end
      SrcDma:
      begin
        winEn       = goSpt | boot | iceStop;       // Host DMA keeps running under emulation stop
        winOp       = dmaCmd.op;
        wrData      = dmaCmd.wrData;
        ackNext.dma = 1'b1;
      end
      SrcBdma:
      begin
        winEn        = goSpt | boot;
        winOp        = bdmaCmd.op;
        wrData       = bdmaCmd.wrData;
        ackNext.bdma = 1'b1;
      end
      default: ;
    endcase
    if (!winEn)
      ackNext = '0;
  end

  assign memOp = winEn ? winOp : OpNone;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      steal <= 1'b0;
      ack   <= '0;
    end
    else
    begin
      steal <= sreq;
      ack   <= ackNext;                             // Every set bit drops again on the next edge
    end
  end

  assign ackBits = ack;

  ackOneHot: assert property (
    @(posedge DSPCLK) disable iff (RST) $onehot0(ackBits)
  ) else $error("stealCtl: more than one acknowledge high");

  ackPulse: assert property (
    @(posedge DSPCLK) disable iff (RST) (|ackBits) |=> ((ackBits & $past(ackBits)) == '0)
  ) else $error("stealCtl: acknowledge held for two cycles");

endmodule

`default_nettype wire

//--- sportAutoBuf.sv
`timescale 1ns/1ps
`default_nettype none

module sportAutoBuf (
  input  logic                               DSPCLK,
  input  logic                               RST,
  input  logic [autoPkg::NumSport-1:0]       rxStrobe,
  input  logic [autoPkg::WordW-1:0]          rxWord [autoPkg::NumSport],
  input  logic [autoPkg::NumSport-1:0]       txTake,
  input  logic [autoPkg::NumSport-1:0]       autoEn,
  input  autoPkg::stealReqT                  ack,
  input  logic [autoPkg::WordW-1:0]          rdData,
  output autoPkg::stealReqT                  req,
  output logic [autoPkg::WordW-1:0]          rxHold [autoPkg::NumSport],
  output logic [autoPkg::WordW-1:0]          txWord [autoPkg::NumSport],
  output logic [autoPkg::NumSport-1:0]       rxOverrun
);
  import autoPkg::*;

  logic [NumSport-1:0] rReq;
  logic [NumSport-1:0] tReq;
  logic [NumSport-1:0] rAck;
  logic [NumSport-1:0] tAck;
  logic [NumSport-1:0] rxLoad;
  logic [NumSport-1:0] txLoad;

  assign rAck = {ack.r1, ack.r0};
  assign tAck = {ack.t1, ack.t0};

  assign rxLoad = rxStrobe & autoEn;                // Strobes are ignored while autobuffering is off
  assign txLoad = txTake & autoEn;

  assign req = '{
    t0:   tReq[0],
    r0:   rReq[0],
    t1:   tReq[1],
    r1:   rReq[1],
    dma:  1'b0,
    bdma: 1'b0
  };

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      rReq      <= '0;
      tReq      <= '0;
      rxOverrun <= '0;
    end
    else
    begin
      for (int p = 0; p < NumSport; p++)
      begin
        if (rxLoad[p])
        begin
          rReq[p] <= 1'b1;
          // Word still waiting for its cycle gets overwritten
          if (rReq[p] && !rAck[p])
            rxOverrun[p] <= 1'b1;
        end
        else if (rAck[p])
        begin
          rReq[p] <= 1'b0;
        end

        if (txLoad[p])
          tReq[p] <= 1'b1;
        else if (tAck[p])
          tReq[p] <= 1'b0;
      end
    end
  end

  always_ff @(posedge DSPCLK)
  begin
    for (int p = 0; p < NumSport; p++)
    begin
      if (rxLoad[p])
        rxHold[p] <= rxWord[p];
      if (tAck[p])
        txWord[p] <= rdData;                        // Read data is valid in the acknowledge cycle
    end
  end

  noAckWithoutReq: assert property (
    @(posedge DSPCLK) disable iff (RST)
    ((rAck & ~rReq) == '0) && ((tAck & ~tReq) == '0)
  ) else $error("sportAutoBuf: acknowledge for a serial request that is low");

endmodule

`default_nettype wire

//--- autoPkg.sv
`default_nettype none

package autoPkg;

  localparam int WordW     = 16;
  localparam int AddrW     = 8;
  localparam int MemDepth  = 256;
  localparam int NumSport  = 2;
  localparam int NumAutoCh = 4;                     // T0, R0, T1, R1 in stealSrcT order

  typedef enum logic [2:0] {
    SrcT0,
    SrcR0,
    SrcT1,
    SrcR1,
    SrcDma,
    SrcBdma,
    SrcNone
  } stealSrcT;

  typedef enum logic [2:0] {
    OpNone,
    OpDmRd,
    OpDmWr,
    OpPmRd,
    OpPmWr
  } memOpT;

  // One bit per requestor, highest priority first
  typedef struct packed {
    logic t0;
    logic r0;
    logic t1;
    logic r1;
    logic dma;
    logic bdma;
  } stealReqT;

  typedef struct packed {
    logic [AddrW-1:0] base;
    logic [AddrW-1:0] len;
  } circCfgT;

  typedef struct packed {
    memOpT            op;
    logic [AddrW-1:0] addr;
    logic [WordW-1:0] wrData;
  } dmaCmdT;

endpackage

`default_nettype wire
